// File: list.f
+incdir+test
common/upsampler_pkg.sv
src/sample_timer.sv
src/ctrl_regs.sv
interp/interp_core.sv
src/sigma_delta.sv
src/upsampler_top.sv
test/tb_upsampler.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the upsampler testbench with verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_upsampler -f list.f -o sim_upsampler
./obj_dir/sim_upsampler | tee sim.log

if grep -qx "TEST RESULT: PASS" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi

// File: test/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// fibonacci lfsr, x^16 + x^14 + x^13 + x^11 + 1
logic [15:0] lfsr_state = 16'd4;

// model of the chain, clocked from the testbench
int                           cnt_m;
logic                         enable_m;
logic                         mute_m;
logic [7:0]                   count_m;
logic signed [acc_width-1:0]  v_m;
logic signed [acc_width-1:0]  v_prev_m;
logic signed [acc_width-1:0]  acc_m;
logic [out_width:0]           sd_m;

function automatic logic [15:0] lfsr_step(input logic [15:0] s);
	return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

// one lfsr step per bit, newest bit lands in the lsb
task automatic take_bits(input int n, output logic [31:0] r);
	r = '0;
	for (int i = 0; i < n; i++) begin
		lfsr_state = lfsr_step(lfsr_state);
		r = {r[30:0], lfsr_state[0]};
	end
endtask

function automatic logic model_tick();
	return enable_m && (cnt_m == ratio - 1);
endfunction

function automatic logic signed [out_width-1:0] model_interp();
	return acc_m[acc_width-1:frac_bits];
endfunction

function automatic logic model_dac();
	return sd_m[out_width];
endfunction

function automatic logic [7:0] model_rdata(input upsampler_pkg::reg_addr_t a);
	logic [7:0] r;
	r = '0;
	if (a == upsampler_pkg::ADDR_CTRL) begin
		r[upsampler_pkg::ctrl_enable_bit] = enable_m;
		r[upsampler_pkg::ctrl_mute_bit]   = mute_m;
	end else begin
		r = count_m;
	end
	return r;
endfunction

// one rising edge of the model, everything computed from the old state first
task automatic model_clock();
	logic                        tick;
	logic signed [out_width-1:0] cur;
	logic [out_width-1:0]        level;
	logic signed [acc_width-1:0] capt;
	logic signed [acc_width-1:0] diff;
	logic signed [acc_width-1:0] step;
	if (reset) begin
		cnt_m = 0;
		enable_m = 1'b0;
		mute_m = 1'b0;
		count_m = '0;
		v_m = '0;
		v_prev_m = '0;
		acc_m = '0;
		sd_m = '0;
	end else begin
		tick = model_tick();
		cur = model_interp();
		// offset binary level into the modulator
		level = {~cur[out_width-1], cur[out_width-2:0]};
		capt = mute_m ? '0 : (acc_width'(v_in) <<< frac_bits);
		diff = v_m - v_prev_m;
		// roughly diff / 25
		step = (diff >>> 5) + (diff >>> 7) + (diff >>> 10) - (diff >>> 15);
		sd_m = {1'b0, sd_m[out_width-1:0]} + {1'b0, level};
		if (tick) begin
			acc_m = v_m;
			v_prev_m = v_m;
			v_m = capt;
			count_m = count_m + 8'd1;
		end else if (enable_m) begin
			acc_m = acc_m + step;
		end
		if (enable_m)
			cnt_m = (cnt_m == ratio - 1) ? 0 : cnt_m + 1;
		if (reg_write && reg_addr == upsampler_pkg::ADDR_CTRL) begin
			enable_m = reg_wdata[upsampler_pkg::ctrl_enable_bit];
			mute_m = reg_wdata[upsampler_pkg::ctrl_mute_bit];
		end
	end
endtask

task automatic report_failure(input string msg);
	error_count++;
	$display("FAILED at %0t: %s", $time, msg);
endtask

task automatic compare_sample(input logic signed [out_width-1:0] got,
		input logic signed [out_width-1:0] exp, input string what);
	check_count++;
	if (got !== exp)
		report_failure($sformatf("%s got %0d expected %0d", what, got, exp));
endtask

task automatic compare_bit(input logic got, input logic exp, input string what);
	check_count++;
	if (got !== exp)
		report_failure($sformatf("%s got %b expected %b", what, got, exp));
endtask

task automatic compare_reg(input upsampler_pkg::reg_addr_t addr, input logic [7:0] got,
		input logic [7:0] exp);
	check_count++;
	if (got !== exp)
		report_failure($sformatf("reg_rdata at %s got %02h expected %02h",
			addr.name(), got, exp));
endtask

`endif

// File: test/tb_upsampler.sv
`timescale 1ns/10ps
`default_nettype none

module tb_upsampler;

	localparam int in_width     = 8;
	localparam int acc_width    = upsampler_pkg::acc_width;
	localparam int frac_bits    = upsampler_pkg::frac_bits;
	localparam int out_width    = upsampler_pkg::out_width;
	localparam int ratio        = upsampler_pkg::upsample_ratio;
	localparam int clock_period = 20;
	// test lengths in sample periods, the watchdog adds a margin for reset
	localparam int len_total    = 2 + 10 + 30 + 5 + 10 + 23;
	localparam int watchdog_ns  = (len_total + 20) * ratio * clock_period;

	logic                          clock;
	logic                          reset;
	logic signed [in_width-1:0]    v_in;
	logic                          reg_write;
	upsampler_pkg::reg_addr_t      reg_addr;
	logic [7:0]                    reg_wdata;
	logic [7:0]                    reg_rdata;
	logic                          sample_req;
	logic signed [out_width-1:0]   interp_out;
	logic                          dac_bit;

	int   error_count;
	int   check_count;
	int   tests_run;
	int   tests_failed;
	int   errors_at_start;
	// strobes already counted into the status register
	int   ticks_done;
	logic tick_pending;

	`include "tb_model.svh"

	upsampler_top #(
		.in_width (in_width)
	) u_dut (
		.clock      (clock),
		.reset      (reset),
		.v_in       (v_in),
		.reg_write  (reg_write),
		.reg_addr   (reg_addr),
		.reg_wdata  (reg_wdata),
		.reg_rdata  (reg_rdata),
		.sample_req (sample_req),
		.interp_out (interp_out),
		.dac_bit    (dac_bit)
	);

	initial begin
		clock = 1'b0;
		forever #(clock_period / 2) clock = ~clock;
	end

	initial begin
		#(watchdog_ns);
		$display("watchdog expired after %0d ns, the tests did not complete", watchdog_ns);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	// model steps on the rising edge, outputs are checked on the falling edge
	task automatic step_clock();
		@(posedge clock);
		if (tick_pending)
			ticks_done++;
		model_clock();
		@(negedge clock);
		compare_bit(sample_req, model_tick(), "sample_req");
		compare_sample(interp_out, model_interp(), "interp_out");
		compare_bit(dac_bit, model_dac(), "dac_bit");
		compare_reg(reg_addr, reg_rdata, model_rdata(reg_addr));
		tick_pending = sample_req;
	endtask

	task automatic write_reg(input upsampler_pkg::reg_addr_t addr, input logic [7:0] data);
		reg_write = 1'b1;
		reg_addr = addr;
		reg_wdata = data;
		step_clock();
		reg_write = 1'b0;
		reg_wdata = '0;
	endtask

	task automatic read_reg(input upsampler_pkg::reg_addr_t addr, input logic [7:0] exp);
		reg_addr = addr;
		step_clock();
		compare_reg(addr, reg_rdata, exp);
	endtask

	task automatic drive_random_sample();
		logic [31:0] r;
		take_bits(in_width, r);
		v_in = r[in_width-1:0];
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (error_count == errors_at_start) begin
			$display("test %0d %s: passed", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: failed with %0d errors", tests_run, name,
				error_count - errors_at_start);
		end
		errors_at_start = error_count;
	endtask

	initial begin
		logic [31:0]                 r;
		logic signed [in_width-1:0]  prev_capture;
		logic signed [out_width-1:0] frozen;
		logic                        was_tick;
		logic                        first;
		int                          gap;
		int                          muted_ticks;
		int                          ones_dut;
		int                          ones_model;
		reset = 1'b1;
		v_in = '0;
		reg_write = 1'b0;
		reg_addr = upsampler_pkg::ADDR_CTRL;
		reg_wdata = '0;
		error_count = 0;
		check_count = 0;
		tests_run = 0;
		tests_failed = 0;
		errors_at_start = 0;
		ticks_done = 0;
		tick_pending = 1'b0;
		prev_capture = '0;
		repeat (5) step_clock();
		reset = 1'b0;

		// registers after reset, readback, status ignores writes
		read_reg(upsampler_pkg::ADDR_CTRL, 8'h00);
		read_reg(upsampler_pkg::ADDR_STATUS, 8'h00);
		compare_bit(sample_req, 1'b0, "sample_req after reset");
		write_reg(upsampler_pkg::ADDR_CTRL, 8'h03);
		read_reg(upsampler_pkg::ADDR_CTRL, 8'h03);
		write_reg(upsampler_pkg::ADDR_CTRL, 8'h00);
		write_reg(upsampler_pkg::ADDR_STATUS, 8'hff);
		read_reg(upsampler_pkg::ADDR_STATUS, 8'h00);
		read_reg(upsampler_pkg::ADDR_CTRL, 8'h00);
		finish_test("reset and register access");

		// one-cycle strobe every 25 clocks, status counts them
		write_reg(upsampler_pkg::ADDR_CTRL, 8'h01);
		reg_addr = upsampler_pkg::ADDR_STATUS;
		gap = 0;
		first = 1'b1;
		repeat (10 * ratio) begin
			step_clock();
			gap++;
			if (sample_req) begin
				if (!first && gap != ratio)
					report_failure($sformatf("sample_req spacing %0d cycles", gap));
				first = 1'b0;
				gap = 0;
			end
			compare_reg(upsampler_pkg::ADDR_STATUS, reg_rdata, 8'(ticks_done));
		end
		if (first)
			report_failure("no sample_req pulse was seen with the timer enabled");
		finish_test("strobe spacing");

		// random stream, post-tick output is the previous-but-one sample
		reg_addr = upsampler_pkg::ADDR_CTRL;
		first = 1'b1;
		repeat (30 * ratio) begin
			drive_random_sample();
			was_tick = model_tick();
			step_clock();
			if (was_tick) begin
				if (!first)
					compare_sample(interp_out, out_width'(prev_capture), "post-tick sample");
				prev_capture = v_in;
				first = 1'b0;
			end
		end
		finish_test("interpolation");

		// two strobes after mute the ramp sits at zero
		write_reg(upsampler_pkg::ADDR_CTRL, 8'h03);
		muted_ticks = 0;
		repeat (5 * ratio) begin
			drive_random_sample();
			was_tick = model_tick();
			step_clock();
			if (was_tick)
				muted_ticks++;
			if (muted_ticks >= 2)
				compare_sample(interp_out, '0, "muted interp_out");
		end
		write_reg(upsampler_pkg::ADDR_CTRL, 8'h01);
		finish_test("mute");

		// stop mid-period at a random point, then resume
		take_bits(5, r);
		repeat (int'(r[4:0]) + 1) begin
			drive_random_sample();
			step_clock();
		end
		write_reg(upsampler_pkg::ADDR_CTRL, 8'h00);
		frozen = model_interp();
		repeat (2 * ratio) begin
			drive_random_sample();
			step_clock();
			compare_bit(sample_req, 1'b0, "sample_req while paused");
			compare_sample(interp_out, frozen, "interp_out while paused");
		end
		write_reg(upsampler_pkg::ADDR_CTRL, 8'h01);
		repeat (6 * ratio) begin
			drive_random_sample();
			step_clock();
		end
		finish_test("enable pause");

		// constant input, let the ramp settle, then count ones
		drive_random_sample();
		repeat (2 * ratio + 2) step_clock();
		ones_dut = 0;
		ones_model = 0;
		repeat (20 * ratio) begin
			step_clock();
			if (dac_bit)
				ones_dut++;
			if (model_dac())
				ones_model++;
		end
		if (ones_dut != ones_model)
			report_failure($sformatf("dac_bit ones %0d expected %0d", ones_dut, ones_model));
		finish_test("modulator");

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, check_count, error_count);
		if (error_count == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: src/upsampler_top.sv
`timescale 1ns/10ps
`default_nettype none

module upsampler_top #(
	parameter int in_width = 8
) (
	input  wire logic                                  clock,
	input  wire logic                                  reset,
	input  wire logic signed [in_width-1:0]            v_in,
	input  wire logic                                  reg_write,
	input  wire upsampler_pkg::reg_addr_t              reg_addr,
	input  wire logic [7:0]                            reg_wdata,
	output logic [7:0]                                 reg_rdata,
	output logic                                       sample_req,
	output logic signed [upsampler_pkg::out_width-1:0] interp_out,
	output logic                                       dac_bit
);

	logic sample_tick;
	logic enable;
	logic mute;

	// the source sees the strobe and holds v_in for capture
	assign sample_req = sample_tick;

	sample_timer u_sample_timer (
		.clock       (clock),
		.reset       (reset),
		.enable      (enable),
		.sample_tick (sample_tick)
	);

	ctrl_regs #(
		.in_width (in_width)
	) u_ctrl_regs (
		.clock       (clock),
		.reset       (reset),
		.reg_write   (reg_write),
		.reg_addr    (reg_addr),
		.reg_wdata   (reg_wdata),
		.reg_rdata   (reg_rdata),
		.sample_tick (sample_tick),
		.enable      (enable),
		.mute        (mute)
	);

	// ramp steps only while the timer runs
	interp_core #(
		.in_width (in_width)
	) u_interp_core (
		.clock       (clock),
		.reset       (reset),
		.v_in        (v_in),
		.sample_tick (sample_tick),
		.step_enable (enable),
		.mute        (mute),
		.interp_out  (interp_out)
	);

	sigma_delta u_sigma_delta (
		.clock      (clock),
		.reset      (reset),
		.interp_out (interp_out),
		.dac_bit    (dac_bit)
	);

endmodule

`default_nettype wire

// File: src/sigma_delta.sv
`timescale 1ns/10ps
`default_nettype none

module sigma_delta (
	input  wire logic                                  clock,
	input  wire logic                                  reset,
	input  wire logic signed [upsampler_pkg::out_width-1:0] interp_out,
	output logic                                       dac_bit
);

	localparam int out_width = upsampler_pkg::out_width;

	// error accumulator with one carry bit on top
	logic [out_width:0]   acc;
	// input as offset binary, full negative maps to zero
	logic [out_width-1:0] level;

	assign level = {~interp_out[out_width-1], interp_out[out_width-2:0]};

	// first order loop
	// the carry out is the quantized bit, the low bits keep the residual error
	always_ff @(posedge clock) begin
		if (reset) begin
			acc <= '0;
		end else begin
			acc <= {1'b0, acc[out_width-1:0]} + {1'b0, level};
		end
	end

	// registered carry, one cycle behind the input
	// density of ones tracks level / 2^out_width
	assign dac_bit = acc[out_width];

endmodule

`default_nettype wire

// File: interp/interp_core.sv
`timescale 1ns/10ps
`default_nettype none

module interp_core #(
	parameter int in_width = 8
) (
	input  wire logic                                 clock,
	input  wire logic                                 reset,
	input  wire logic signed [in_width-1:0]           v_in,
	input  wire logic                                 sample_tick,
	input  wire logic                                 step_enable,
	input  wire logic                                 mute,
	output logic signed [upsampler_pkg::out_width-1:0] interp_out
);

	localparam int acc_width = upsampler_pkg::acc_width;
	localparam int frac_bits = upsampler_pkg::frac_bits;
	// guard bits above the sample msb
	localparam int ext_bits  = acc_width - in_width - frac_bits;

	// newest and previous sample, both in accumulator format
	logic signed [acc_width-1:0] v;
	logic signed [acc_width-1:0] v_prev;
	// running interpolated value
	logic signed [acc_width-1:0] acc;
	logic signed [acc_width-1:0] v_capture;
	logic signed [acc_width-1:0] v_diff;
	logic signed [acc_width-1:0] v_step;

	// sign extend the input and move it above the fraction bits
	// muted samples are captured as zero
	assign v_capture = mute ? '0 :
		{{ext_bits{v_in[in_width-1]}}, v_in, {frac_bits{1'b0}}};

	assign v_diff = v - v_prev;

	// one twenty-fifth of the difference
	// 2^-5 + 2^-7 + 2^-10 - 2^-15 comes to about 0.04
	assign v_step = (v_diff >>> 5) + (v_diff >>> 7) + (v_diff >>> 10)
		- (v_diff >>> 15);

	always_ff @(posedge clock) begin
		if (reset) begin
			v      <= '0;
			v_prev <= '0;
			acc    <= '0;
		end else if (sample_tick) begin
			v_prev <= v;
			v      <= v_capture;
			// restart the ramp from the older sample
			acc    <= v;
		end else if (step_enable) begin
			acc <= acc + v_step;
		end
		// timer stopped, whole ramp holds
	end

	// drop the fraction bits
	assign interp_out = acc[acc_width-1:frac_bits];

	// ramp only moves on a strobe or while the timer runs
	acc_hold: assert property (
		@(posedge clock) disable iff (reset)
		(!sample_tick && !step_enable) |=> $stable(acc)
	);

endmodule

`default_nettype wire

// File: src/ctrl_regs.sv
`timescale 1ns/10ps
`default_nettype none

module ctrl_regs #(
	parameter int in_width = 8
) (
	input  wire logic                     clock,
	input  wire logic                     reset,
	input  wire logic                     reg_write,
	input  wire upsampler_pkg::reg_addr_t reg_addr,
	input  wire logic [7:0]               reg_wdata,
	output logic [7:0]                    reg_rdata,
	input  wire logic                     sample_tick,
	output logic                          enable,
	output logic                          mute
);

	// samples taken, wraps at 256
	logic [7:0] sample_count;
	logic       ctrl_write;

	// status is read-only, only the control address takes writes
	assign ctrl_write = reg_write && (reg_addr == upsampler_pkg::ADDR_CTRL);

	always_ff @(posedge clock) begin
		if (reset) begin
			enable <= 1'b0;
			mute   <= 1'b0;
		end else if (ctrl_write) begin
			enable <= reg_wdata[upsampler_pkg::ctrl_enable_bit];
			mute   <= reg_wdata[upsampler_pkg::ctrl_mute_bit];
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			sample_count <= '0;
		end else if (sample_tick) begin
			sample_count <= sample_count + 1'b1;
		end
	end

	// read mux, control bits in place and zeros elsewhere
	always_comb begin
		reg_rdata = '0;
		case (reg_addr)
			upsampler_pkg::ADDR_CTRL: begin
				reg_rdata[upsampler_pkg::ctrl_enable_bit] = enable;
				reg_rdata[upsampler_pkg::ctrl_mute_bit]   = mute;
			end
			upsampler_pkg::ADDR_STATUS: reg_rdata = sample_count;
			default: reg_rdata = '0;
		endcase
	end

	// a full-scale sample plus fraction must leave a guard bit in the interpolator
	width_fits: assert property (
		@(posedge clock)
		(in_width + upsampler_pkg::frac_bits) < upsampler_pkg::acc_width
	);

endmodule

`default_nettype wire

// File: src/sample_timer.sv
`timescale 1ns/10ps
`default_nettype none

module sample_timer (
	input  wire logic clock,
	input  wire logic reset,
	input  wire logic enable,
	output logic      sample_tick
);

	localparam int cnt_width = $clog2(upsampler_pkg::upsample_ratio);

	// position inside the current sample period
	logic [cnt_width-1:0] count;
	logic                 terminal;

	// last clock of the period
	assign terminal = (count == cnt_width'(upsampler_pkg::upsample_ratio - 1));

	always_ff @(posedge clock) begin
		if (reset) begin
			count <= '0;
		end else if (enable) begin
			if (terminal) begin
				count <= '0;
			end else begin
				count <= count + 1'b1;
			end
		end
		// stopped timer keeps its count, resumes from there
	end

	// strobe only while running
	assign sample_tick = enable && terminal;

	// the next strobe comes no sooner than a full period later
	tick_spacing: assert property (
		@(posedge clock) disable iff (reset)
		sample_tick |=> (!sample_tick) [*(upsampler_pkg::upsample_ratio - 1)]
	);

endmodule

`default_nettype wire

// File: common/upsampler_pkg.sv
`default_nettype none

package upsampler_pkg;

	// clocks per input sample, the divide-by-25 shift terms are tied to this
	localparam int upsample_ratio = 25;

	// interpolation accumulator and its fixed-point split
	localparam int acc_width = 32;
	// fraction bits below the sample lsb
	localparam int frac_bits = 12;
	// interpolated output is the accumulator's upper bits
	localparam int out_width = acc_width - frac_bits;

	// register map, one address bit
	typedef enum logic [0:0] {
		ADDR_CTRL   = 1'b0,
		ADDR_STATUS = 1'b1
	} reg_addr_t;

	// bit positions inside the control register
	localparam int ctrl_enable_bit = 0;
	localparam int ctrl_mute_bit   = 1;

endpackage

`default_nettype wire
